/* mul_pkg.sv */
`default_nettype none

package mul_pkg;

  localparam int SWITCH_WIDTH    = 16;
  localparam int OPERAND_WIDTH   = 64;
  localparam int PRODUCT_WIDTH   = 2 * OPERAND_WIDTH;       // full unsigned product
  localparam int BITS_DROPPED    = 64;
  localparam int RESULT_WIDTH    = PRODUCT_WIDTH - BITS_DROPPED;
  localparam int BIT_INDEX_WIDTH = $clog2(RESULT_WIDTH);

  // limb decomposition of the pipelined multiplier
  localparam int LIMB_WIDTH      = 16;
  localparam int LIMB_COUNT      = OPERAND_WIDTH / LIMB_WIDTH;
  localparam int COLUMN_COUNT    = 2 * LIMB_COUNT - 1;      // distinct limb weights i+j
  localparam int COLUMN_WIDTH    = 2 * LIMB_WIDTH + 2;      // up to four products per column
  localparam int LOW_SUM_WIDTH   = 3 * LIMB_WIDTH + COLUMN_WIDTH + 1;
  localparam int PIPE_STAGES     = 4;

  typedef logic [SWITCH_WIDTH-1:0]    switch_t;
  typedef logic [OPERAND_WIDTH-1:0]   operand_t;
  typedef logic [RESULT_WIDTH-1:0]    result_t;
  typedef logic [BIT_INDEX_WIDTH-1:0] bit_index_t;
  typedef logic [LIMB_WIDTH-1:0]      limb_t;
  typedef logic [2*LIMB_WIDTH-1:0]    limb_product_t;
  typedef logic [COLUMN_WIDTH-1:0]    column_t;

  // one multiplication request, valid is a single-cycle strobe
  typedef struct packed {
    operand_t a;
    operand_t b;
    logic     valid;
  } mul_req_t;

  // upper half of the product with its strobe
  typedef struct packed {
    result_t product;
    logic    valid;
  } mul_rsp_t;

endpackage

`default_nettype wire

/* operand_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module operand_capture (
  input  logic              clk_100mhz,
  input  logic              rst_n,
  input  mul_pkg::switch_t  sw,
  input  logic              start,
  output mul_pkg::mul_req_t req
);
  import mul_pkg::*;

  switch_t  sw_mirror;
  logic     start_meta;      // first synchronizer flop
  logic     start_sync;      // synchronized button level
  logic     start_sync_d;    // delayed copy for edge detection
  logic     start_rise;
  logic     valid_q;
  operand_t a_q;
  operand_t b_q;

  assign sw_mirror  = {<<{sw}};                       // bit 15 swaps with bit 0 and so on
  assign start_rise = start_sync & ~start_sync_d;

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      start_meta   <= 1'b0;
      start_sync   <= 1'b0;
      start_sync_d <= 1'b0;
      valid_q      <= 1'b0;
    end else begin
      start_meta   <= start;
      start_sync   <= start_meta;
      start_sync_d <= start_sync;
      valid_q      <= start_rise;                     // one pulse per press
    end
  end

  // operands are taken from the switches together with the pulse
  always_ff @(posedge clk_100mhz) begin
    if (start_rise) begin
      a_q <= {sw_mirror, sw, sw_mirror, sw};
      b_q <= {sw, sw_mirror, sw, sw_mirror};
    end
  end

  assign req = '{a: a_q, b: b_q, valid: valid_q};

endmodule

`default_nettype wire

/* lazy_multiplier.sv */
`timescale 1ns/100ps
`default_nettype none

module lazy_multiplier (
  input  logic              clk_100mhz,
  input  logic              rst_n,
  input  mul_pkg::mul_req_t req,
  output mul_pkg::mul_rsp_t rsp
);
  import mul_pkg::*;

  logic [PRODUCT_WIDTH-1:0] full_product;
  mul_rsp_t                 rsp_q;

  // the whole 64x64 product in one cycle, long carry chain in hardware
  assign full_product = PRODUCT_WIDTH'(req.a) * PRODUCT_WIDTH'(req.b);

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      rsp_q <= '0;
    end else begin
      rsp_q.valid <= req.valid;
      if (req.valid) begin
        rsp_q.product <= full_product[BITS_DROPPED +: RESULT_WIDTH];  // keep the high half
      end
    end
  end

  assign rsp = rsp_q;

endmodule

`default_nettype wire

/* pipelined_multiplier.sv */
`timescale 1ns/100ps
`default_nettype none

module pipelined_multiplier (
  input  logic              clk_100mhz,
  input  logic              rst_n,
  input  mul_pkg::mul_req_t req,
  output mul_pkg::mul_rsp_t rsp
);
  import mul_pkg::*;

  limb_t         a_limb [LIMB_COUNT];
  limb_t         b_limb [LIMB_COUNT];
  limb_product_t pp_q   [LIMB_COUNT][LIMB_COUNT];    // stage 1
  column_t       col_d  [COLUMN_COUNT];
  column_t       col_q  [COLUMN_COUNT];              // stage 2
  logic [LOW_SUM_WIDTH-1:0]               low_d;
  result_t                                high_d;
  logic [LOW_SUM_WIDTH-OPERAND_WIDTH-1:0] carry_q;   // stage 3, carry into bit 64
  result_t                                high_q;
  result_t                                product_q; // stage 4
  logic [PIPE_STAGES-1:0]                 valid_pipe;

  always_comb begin
    for (int i = 0; i < LIMB_COUNT; i++) begin
      a_limb[i] = req.a[i*LIMB_WIDTH +: LIMB_WIDTH];
      b_limb[i] = req.b[i*LIMB_WIDTH +: LIMB_WIDTH];
    end
  end

  // stage 1: all sixteen 16x16 limb products
  always_ff @(posedge clk_100mhz) begin
    for (int i = 0; i < LIMB_COUNT; i++) begin
      for (int j = 0; j < LIMB_COUNT; j++) begin
        pp_q[i][j] <= limb_product_t'(a_limb[i]) * limb_product_t'(b_limb[j]);
      end
    end
  end

  // stage 2: products of equal weight i+j summed into one column
  always_comb begin
    for (int k = 0; k < COLUMN_COUNT; k++) begin
      col_d[k] = '0;
    end
    for (int i = 0; i < LIMB_COUNT; i++) begin
      for (int j = 0; j < LIMB_COUNT; j++) begin
        col_d[i+j] = col_d[i+j] + column_t'(pp_q[i][j]);
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    col_q <= col_d;
  end

  // stage 3: low columns give the carry into the kept half,
  // high columns are summed relative to bit 64 (mod 2^64 is enough)
  always_comb begin
    low_d  = '0;
    high_d = '0;
    for (int k = 0; k < COLUMN_COUNT; k++) begin
      if (k < LIMB_COUNT) begin
        low_d = low_d + (LOW_SUM_WIDTH'(col_q[k]) << (k * LIMB_WIDTH));
      end else begin
        high_d = high_d + (RESULT_WIDTH'(col_q[k]) << ((k - LIMB_COUNT) * LIMB_WIDTH));
      end
    end
  end

  always_ff @(posedge clk_100mhz) begin
    carry_q <= low_d[LOW_SUM_WIDTH-1:OPERAND_WIDTH];
    high_q  <= high_d;
  end

  // stage 4 and the valid that travels with the data
  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      valid_pipe <= '0;
      product_q  <= '0;
    end else begin
      valid_pipe <= {valid_pipe[PIPE_STAGES-2:0], req.valid};
      if (valid_pipe[PIPE_STAGES-2]) begin
        product_q <= high_q + RESULT_WIDTH'(carry_q);
      end
    end
  end

  assign rsp = '{product: product_q, valid: valid_pipe[PIPE_STAGES-1]};

endmodule

`default_nettype wire

/* result_scanner.sv */
`timescale 1ns/100ps
`default_nettype none

module result_scanner (
  input  logic                clk_100mhz,
  input  logic                rst_n,
  input  mul_pkg::mul_rsp_t   rsp_lazy,
  input  mul_pkg::mul_rsp_t   rsp_pipe,
  output logic                led_lazy,
  output logic                led_hard,
  output mul_pkg::bit_index_t bit_index,
  output logic                mismatch
);
  import mul_pkg::*;

  result_t    lazy_q;        // latest lazy result
  result_t    pipe_q;        // latest pipelined result
  bit_index_t bit_index_q;
  logic       mismatch_q;

  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      lazy_q <= '0;
      pipe_q <= '0;
    end else begin
      if (rsp_lazy.valid) begin
        lazy_q <= rsp_lazy.product;
      end
      if (rsp_pipe.valid) begin
        pipe_q <= rsp_pipe.product;
      end
    end
  end

  // free-running scan position, wraps from 63 to 0
  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      bit_index_q <= '0;
    end else begin
      bit_index_q <= bit_index_q + bit_index_t'(1);
    end
  end

  // one cycle behind the latches
  always_ff @(posedge clk_100mhz) begin
    if (!rst_n) begin
      mismatch_q <= 1'b0;
    end else begin
      mismatch_q <= (lazy_q != pipe_q);
    end
  end

  assign led_lazy  = lazy_q[bit_index_q];
  assign led_hard  = pipe_q[bit_index_q];
  assign bit_index = bit_index_q;
  assign mismatch  = mismatch_q;

endmodule

`default_nettype wire

/* mul_compare_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mul_compare_top (
  input  logic                clk_100mhz,
  input  logic                rst_n,
  input  mul_pkg::switch_t    sw,
  input  logic                start,
  output logic                led_lazy,
  output logic                led_hard,
  output mul_pkg::bit_index_t bit_index,
  output logic                mismatch,
  output mul_pkg::result_t    product_lazy,
  output mul_pkg::result_t    product_hard,
  output logic                lazy_valid,
  output logic                hard_valid
);
  import mul_pkg::*;

  mul_req_t req;
  mul_rsp_t rsp_lazy;
  mul_rsp_t rsp_pipe;

  operand_capture operand_capture_i (
    .clk_100mhz (clk_100mhz),
    .rst_n      (rst_n),
    .sw         (sw),
    .start      (start),
    .req        (req)
  );

  lazy_multiplier lazy_multiplier_i (
    .clk_100mhz (clk_100mhz),
    .rst_n      (rst_n),
    .req        (req),
    .rsp        (rsp_lazy)
  );

  pipelined_multiplier pipelined_multiplier_i (
    .clk_100mhz (clk_100mhz),
    .rst_n      (rst_n),
    .req        (req),
    .rsp        (rsp_pipe)
  );

  result_scanner result_scanner_i (
    .clk_100mhz (clk_100mhz),
    .rst_n      (rst_n),
    .rsp_lazy   (rsp_lazy),
    .rsp_pipe   (rsp_pipe),
    .led_lazy   (led_lazy),
    .led_hard   (led_hard),
    .bit_index  (bit_index),
    .mismatch   (mismatch)
  );

  // raw responses, in place of the board's result display
  assign product_lazy = rsp_lazy.product;
  assign product_hard = rsp_pipe.product;
  assign lazy_valid   = rsp_lazy.valid;
  assign hard_valid   = rsp_pipe.valid;

endmodule

`default_nettype wire

/* mul_compare_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module mul_compare_assert (
  input  logic                clk_100mhz,
  input  logic                rst_n,
  input  mul_pkg::mul_rsp_t   rsp_lazy,
  input  mul_pkg::mul_rsp_t   rsp_pipe,
  input  mul_pkg::bit_index_t bit_index,
  input  logic                mismatch
);
  import mul_pkg::*;

  // an isolated request: lazy strobe 3 cycles before the pipelined one and no newer lazy
  // result until both latches settle, mismatch is sampled 3 cycles after the pipe strobe
  assert property (@(posedge clk_100mhz) disable iff (!rst_n)
    $past(rsp_pipe.valid, 3) && $past(rsp_lazy.valid, 6) && !$past(rsp_lazy.valid, 5) &&
    !$past(rsp_lazy.valid, 4) && !$past(rsp_lazy.valid, 3) |-> !mismatch)
    else $error("mismatch raised although both results came from one request");

  assert property (@(posedge clk_100mhz) disable iff (!rst_n)
    !$isunknown({rsp_lazy.valid, rsp_pipe.valid}))
    else $error("response valid is unknown after reset");

  assert property (@(posedge clk_100mhz) disable iff (!rst_n)
    $past(rst_n) |-> bit_index == $past(bit_index) + bit_index_t'(1))
    else $error("bit_index did not step by one modulo 64");

endmodule

bind result_scanner mul_compare_assert mul_compare_assert_i (
  .clk_100mhz (clk_100mhz),
  .rst_n      (rst_n),
  .rsp_lazy   (rsp_lazy),
  .rsp_pipe   (rsp_pipe),
  .bit_index  (bit_index),
  .mismatch   (mismatch)
);

`default_nettype wire

/* tb_mul_compare.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mul_compare;
  import mul_pkg::*;

  localparam int CYCLE_LIMIT = 4000;    // several times what all tests together need
  localparam int WAIT_LIMIT  = 20;      // longest expected strobe latency is 7

  logic        clk_100mhz;
  logic        rst_n;
  switch_t     sw;
  logic        start;
  logic        led_lazy;
  logic        led_hard;
  bit_index_t  bit_index;
  logic        mismatch;
  result_t     product_lazy;
  result_t     product_hard;
  logic        lazy_valid;
  logic        hard_valid;
  int          cycle_count;
  int          errors;
  int          checks;
  int          tests_run;
  int          test_start_errors;
  string       test_name;
  logic [31:0] rng_state = 32'd22094;

  mul_compare_top mul_compare_top_i (
    .clk_100mhz   (clk_100mhz),
    .rst_n        (rst_n),
    .sw           (sw),
    .start        (start),
    .led_lazy     (led_lazy),
    .led_hard     (led_hard),
    .bit_index    (bit_index),
    .mismatch     (mismatch),
    .product_lazy (product_lazy),
    .product_hard (product_hard),
    .lazy_valid   (lazy_valid),
    .hard_valid   (hard_valid)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  always @(posedge clk_100mhz) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= CYCLE_LIMIT);
    $display("timeout after %0d cycles, a test never completed", CYCLE_LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // upper half of the 128-bit product of the two concatenated operands
  function automatic result_t model_product(switch_t s);
    switch_t      m;
    logic [127:0] p;
    for (int i = 0; i < 16; i++)
      m[i] = s[15-i];                   // mirrored switches
    p = {64'd0, m, s, m, s} * {64'd0, s, m, s, m};
    return p[127:64];
  endfunction

  task automatic compare_result(string what, result_t expected, result_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_index(string what, bit_index_t expected, bit_index_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_flag(string what, logic expected, logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s %s: expected %b, actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_count(string what, int expected, int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("Error %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic begin_test(string name);
    test_name = name;
    test_start_errors = errors;
    tests_run++;
  endtask

  task automatic end_test();
    $display("test %s done, %0d errors", test_name, errors - test_start_errors);
  endtask

  // returns at the falling edge where the strobe is seen
  task automatic wait_valid(input bit hard, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk_100mhz);
      cycles++;
    end while (!(hard ? hard_valid : lazy_valid) && cycles < WAIT_LIMIT);
    if (!(hard ? hard_valid : lazy_valid)) begin
      errors++;
      $display("%s: %s did not pulse within %0d cycles", test_name,
               hard ? "hard_valid" : "lazy_valid", WAIT_LIMIT);
    end
  endtask

  task automatic press_and_check(switch_t value);
    int      cycles;
    result_t expected;
    expected = model_product(value);
    sw       = value;
    start    = 1'b1;
    wait_valid(1'b0, cycles);
    compare_result("product_lazy", expected, product_lazy);
    wait_valid(1'b1, cycles);
    compare_count("cycles from lazy_valid to hard_valid", 3, cycles);
    compare_result("product_hard", expected, product_hard);
    start = 1'b0;
    repeat (4) @(negedge clk_100mhz);   // let the synchronizer see the release
  endtask

  task automatic reset_state_test();
    begin_test("reset_state");
    compare_flag("lazy_valid", 1'b0, lazy_valid);
    compare_flag("hard_valid", 1'b0, hard_valid);
    compare_flag("mismatch", 1'b0, mismatch);
    compare_result("product_lazy", '0, product_lazy);
    compare_result("product_hard", '0, product_hard);
    compare_index("bit_index", '0, bit_index);
    end_test();
  endtask

  task automatic single_press_test();
    begin_test("single_press");
    repeat (20) press_and_check(switch_t'(next_random()));
    end_test();
  endtask

  task automatic held_button_test();
    int lazy_pulses;
    int hard_pulses;
    begin_test("held_button");
    lazy_pulses = 0;
    hard_pulses = 0;
    sw    = switch_t'(next_random());
    start = 1'b1;
    for (int n = 0; n < 40; n++) begin
      @(negedge clk_100mhz);
      if (n == 29)
        start = 1'b0;                   // released after 30 cycles
      lazy_pulses += int'(lazy_valid);
      hard_pulses += int'(hard_valid);
    end
    compare_count("lazy_valid pulses", 1, lazy_pulses);
    compare_count("hard_valid pulses", 1, hard_pulses);
    end_test();
  endtask

  task automatic pipelining_test();
    switch_t values [8];
    int      cycles;
    begin_test("pipelining");
    foreach (values[k])
      values[k] = switch_t'(next_random());
    fork
      begin
        // sw is sampled two cycles after start rises, so it lags one press behind
        for (int k = 0; k <= 8; k++) begin
          start = (k < 8);
          if (k > 0)
            sw = values[k-1];
          @(negedge clk_100mhz);
          start = 1'b0;
          @(negedge clk_100mhz);
        end
      end
      begin
        for (int r = 0; r < 8; r++) begin
          wait_valid(1'b1, cycles);
          if (r > 0)
            compare_count("cycles between hard_valid pulses", 2, cycles);  // one press per 2
          compare_result("product_hard", model_product(values[r]), product_hard);
        end
      end
    join
    repeat (4) @(negedge clk_100mhz);
    end_test();
  endtask

  task automatic led_scan_test();
    switch_t    value;
    result_t    expected;
    bit_index_t previous;
    begin_test("led_scan");
    value    = switch_t'(next_random());
    expected = model_product(value);
    press_and_check(value);
    previous = bit_index;
    repeat (64) begin
      @(negedge clk_100mhz);
      compare_index("bit_index", previous + bit_index_t'(1), bit_index);
      compare_flag("led_lazy", expected[bit_index], led_lazy);
      compare_flag("led_hard", expected[bit_index], led_hard);
      previous = bit_index;
    end
    end_test();
  endtask

  task automatic no_mismatch_test();
    switch_t values [4] = '{16'h0000, 16'hffff, 16'h8001, 16'h7ffe};
    begin_test("no_mismatch");
    foreach (values[k]) begin
      press_and_check(values[k]);
      compare_flag("mismatch", 1'b0, mismatch);
    end
    end_test();
  endtask

  initial begin
    rst_n     = 1'b0;
    start     = 1'b0;
    sw        = '0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    repeat (8) @(negedge clk_100mhz);
    rst_n = 1'b1;
    reset_state_test();
    single_press_test();
    held_button_test();
    pipelining_test();
    led_scan_test();
    no_mismatch_test();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
mul_pkg.sv
operand_capture.sv
lazy_multiplier.sv
pipelined_multiplier.sv
result_scanner.sv
mul_compare_top.sv
mul_compare_assert.sv
tb_mul_compare.sv

/* Makefile */
# Verilator build and run of the multiplier comparison testbench
TOP := tb_mul_compare

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
